//--- compile.f
src/rv_isa_pkg.sv
src/core_bus_pkg.sv
src/instr_decoder.sv
src/alu.sv
src/register_file.sv
src/core_sequencer.sv
src/cpu_core.sv
sim/tb_cpu_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cpu_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f compile.f --top-module tb_cpu_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
exit 1

//--- sim/program.hex
// one 32-bit word per line from byte address 0: program, then the load data word at 0xAC
FFB00093 // 00 addi x1, x0, -5
00C00113 // 04 addi x2, x0, 12
002081B3 // 08 add  x3, x1, x2
40208233 // 0c sub  x4, x1, x2
0020C2B3 // 10 xor  x5, x1, x2
0020E333 // 14 or   x6, x1, x2
0020F3B3 // 18 and  x7, x1, x2
00411413 // 1c slli x8, x2, 4
0020D4B3 // 20 srl  x9, x1, x2
ABCDE537 // 24 lui  x10, 0xabcde
06300013 // 28 addi x0, x0, 99
10302023 // 2c sw x3, 0x100(x0)
10402223 // 30 sw x4, 0x104(x0)
10502423 // 34 sw x5, 0x108(x0)
10602623 // 38 sw x6, 0x10c(x0)
10702823 // 3c sw x7, 0x110(x0)
10802A23 // 40 sw x8, 0x114(x0)
10902C23 // 44 sw x9, 0x118(x0)
10A02E23 // 48 sw x10, 0x11c(x0)
12002023 // 4c sw x0, 0x120(x0)
0AC02583 // 50 lw x11, 0xac(x0)
00358593 // 54 addi x11, x11, 3
12B02223 // 58 sw x11, 0x124(x0)
00208463 // 5c beq x1, x2, +8 not taken
12202423 // 60 sw x2, 0x128(x0)
00210463 // 64 beq x2, x2, +8 taken
1E102E23 // 68 poison sw x1, 0x1fc(x0)
00211463 // 6c bne x2, x2, +8 not taken
12302623 // 70 sw x3, 0x12c(x0)
00209463 // 74 bne x1, x2, +8 taken
1E102E23 // 78 poison
0020C463 // 7c blt x1, x2, +8 not taken unsigned
12402823 // 80 sw x4, 0x130(x0)
00114463 // 84 blt x2, x1, +8 taken
1E102E23 // 88 poison
00115463 // 8c bge x2, x1, +8 not taken
12502A23 // 90 sw x5, 0x134(x0)
0020D463 // 94 bge x1, x2, +8 taken
1E102E23 // 98 poison
0080066F // 9c jal x12, +8
1E102E23 // a0 poison
12C02C23 // a4 sw x12, 0x138(x0)
0000006F // a8 jal x0, 0
12345678 // ac load data

//--- sim/tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core;

    localparam int MEM_WORDS  = 128;
    localparam int NUM_STORES = 15;
    localparam int WAIT_LIMIT = 4000; // cycles
    localparam rv_isa_pkg::word_t LOOP_ADDR = 32'h0000_00A8; // final jal to self

    logic                   clk;
    logic                   rst = 1'b1;
    logic                   bus_full = 1'b0;
    core_bus_pkg::bus_req_t bus_req;
    rv_isa_pkg::word_t      bus_rdata;

    rv_isa_pkg::word_t      mem [MEM_WORDS];
    logic [15:0]            lfsr = 16'd26;
    int                     store_idx = 0;
    logic                   done = 1'b0;
    logic                   first_req = 1'b1;
    logic                   prev_stalled = 1'b0;
    core_bus_pkg::bus_req_t prev_req;

    // store addresses and data in program order
    rv_isa_pkg::word_t exp_addr [NUM_STORES] = '{
        32'h100, 32'h104, 32'h108, 32'h10C, 32'h110,
        32'h114, 32'h118, 32'h11C, 32'h120, 32'h124,
        32'h128, 32'h12C, 32'h130, 32'h134, 32'h138};
    rv_isa_pkg::word_t exp_data [NUM_STORES] = '{
        32'h0000_0007, 32'hFFFF_FFEF, 32'hFFFF_FFF7, 32'hFFFF_FFFF, 32'h0000_0008,
        32'h0000_00C0, 32'h000F_FFFF, 32'hABCD_E000, 32'h0000_0000, 32'h1234_567B,
        32'h0000_000C, 32'h0000_0007, 32'hFFFF_FFEF, 32'hFFFF_FFF7, 32'h0000_00A0};

    cpu_core cpu_core_i (
        .clk         (clk),
        .rst         (rst),
        .bus_req_o   (bus_req),
        .bus_rdata_i (bus_rdata),
        .bus_full_i  (bus_full)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input rv_isa_pkg::word_t got,
                               input rv_isa_pkg::word_t exp);
        assert (got === exp)
        else stop_run($sformatf("Fail at %0t ns: %s = %h, expected %h",
                                $time, name, got, exp));
    endtask

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic lfsr_bit();
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return lfsr[0];
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hBAD0_0000 | (i << 2); // unused words carry their byte address
        end
        $readmemh("sim/program.hex", mem);
    end

    assign bus_rdata = mem[bus_req.addr[8:2]]; // combinational read

    always @(posedge clk) begin
        if (!rst && bus_req.wr && !bus_full) begin
            mem[bus_req.addr[8:2]] = bus_req.wdata;
        end
    end

    // stall roughly one cycle in four
    always @(posedge clk) begin
        if (rst) begin
            bus_full <= 1'b0;
        end else begin
            bus_full <= lfsr_bit() & lfsr_bit();
        end
    end

    // request and stall level are both settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            assert (!bus_req.wr) else stop_run("write strobe went high during reset");
            prev_stalled = 1'b0;
        end else begin
            if (first_req) begin
                check_value("bus_req_o.rd", 32'(bus_req.rd), 32'd1);
                check_value("bus_req_o.wr", 32'(bus_req.wr), 32'd0);
                check_value("bus_req_o.addr", bus_req.addr, 32'h0);
                first_req = 1'b0;
            end
            if (prev_stalled) begin // request must hold while the bus is full
                check_value("bus_req_o.rd", 32'(bus_req.rd), 32'(prev_req.rd));
                check_value("bus_req_o.wr", 32'(bus_req.wr), 32'(prev_req.wr));
                check_value("bus_req_o.addr", bus_req.addr, prev_req.addr);
                check_value("bus_req_o.wdata", bus_req.wdata, prev_req.wdata);
            end
            if (bus_req.wr && !bus_full) begin
                assert (store_idx < NUM_STORES)
                else stop_run($sformatf("unexpected store to address %h", bus_req.addr));
                check_value("bus_req_o.addr", bus_req.addr, exp_addr[store_idx]);
                check_value("bus_req_o.wdata", bus_req.wdata, exp_data[store_idx]);
                store_idx++;
            end
            if (store_idx == NUM_STORES && bus_req.rd && bus_req.addr == LOOP_ADDR) begin
                done = 1'b1;
            end
            prev_req     = bus_req;
            prev_stalled = (bus_req.rd || bus_req.wr) && bus_full;
        end
    end

    initial begin
        int cycles;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            stop_run($sformatf(
                "timeout: program did not reach its end loop in %0d cycles, %0d stores seen",
                cycles, store_idx));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- src/alu.sv
`timescale 1ns/1ns

module alu (
    input  rv_isa_pkg::decoded_t dec_i,
    input  rv_isa_pkg::word_t    rs1_data_i,
    input  rv_isa_pkg::word_t    rs2_data_i,
    input  rv_isa_pkg::word_t    pc_i,
    output rv_isa_pkg::word_t    alu_result_o,
    output rv_isa_pkg::word_t    mem_addr_o,
    output logic                 branch_taken_o
);

    rv_isa_pkg::word_t op_b;
    logic              do_sub;

    always_comb begin
        op_b   = dec_i.use_imm ? dec_i.imm : rs2_data_i;
        // sub only exists for the register form
        do_sub = (dec_i.opcode == rv_isa_pkg::OP_REG) && (dec_i.funct7 == rv_isa_pkg::F7_SUB);
    end

    always_comb begin
        alu_result_o = '0;
        case (dec_i.opcode)
            rv_isa_pkg::OP_REG, rv_isa_pkg::OP_IMM: begin
                case (dec_i.funct3)
                    rv_isa_pkg::F3_ADD, rv_isa_pkg::F3_SLT: begin
                        alu_result_o = do_sub ? rs1_data_i - op_b : rs1_data_i + op_b;
                    end
                    rv_isa_pkg::F3_SLL: alu_result_o = rs1_data_i << op_b[4:0];
                    rv_isa_pkg::F3_XOR: alu_result_o = rs1_data_i ^ op_b;
                    rv_isa_pkg::F3_SRL: alu_result_o = rs1_data_i >> op_b[4:0]; // logical
                    rv_isa_pkg::F3_OR:  alu_result_o = rs1_data_i | op_b;
                    rv_isa_pkg::F3_AND: alu_result_o = rs1_data_i & op_b;
                    default:            alu_result_o = '0;
                endcase
            end
            rv_isa_pkg::OP_LUI: alu_result_o = dec_i.imm; // already shifted by decoder
            rv_isa_pkg::OP_JAL: alu_result_o = pc_i + core_bus_pkg::PC_STEP; // link value
            default:            alu_result_o = '0;
        endcase
    end

    // loads and stores share one address adder
    assign mem_addr_o = rs1_data_i + dec_i.imm;

    // unsigned compare throughout
    always_comb begin
        branch_taken_o = 1'b0;
        if (dec_i.is_branch) begin
            case (dec_i.funct3)
                rv_isa_pkg::F3_BEQ: branch_taken_o = (rs1_data_i == rs2_data_i);
                rv_isa_pkg::F3_BNE: branch_taken_o = (rs1_data_i != rs2_data_i);
                rv_isa_pkg::F3_BLT: branch_taken_o = (rs1_data_i <  rs2_data_i);
                rv_isa_pkg::F3_BGE: branch_taken_o = (rs1_data_i >= rs2_data_i);
                default:            branch_taken_o = 1'b0;
            endcase
        end
    end

endmodule

//--- src/core_bus_pkg.sv
package core_bus_pkg;

    // one request on the shared instruction/data bus
    typedef struct packed {
        logic              rd;
        logic              wr;
        rv_isa_pkg::word_t addr;   // byte address of a word
        rv_isa_pkg::word_t wdata;
    } bus_req_t;

    // one instruction in flight at a time
    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM
    } seq_state_t;

    localparam rv_isa_pkg::word_t RESET_PC = 32'h0000_0000;
    localparam rv_isa_pkg::word_t PC_STEP  = 32'd4;

endpackage

//--- src/core_sequencer.sv
`timescale 1ns/1ns

module core_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_isa_pkg::decoded_t   dec_i,
    input  rv_isa_pkg::word_t      alu_result_i,
    input  rv_isa_pkg::word_t      mem_addr_i,
    input  rv_isa_pkg::word_t      store_data_i,
    input  logic                   branch_taken_i,
    output rv_isa_pkg::word_t      instr_o,
    output rv_isa_pkg::word_t      pc_o,
    output logic                   rf_we_o,
    output rv_isa_pkg::reg_addr_t  rf_rd_o,
    output rv_isa_pkg::word_t      rf_wdata_o,
    output core_bus_pkg::bus_req_t bus_req_o,
    input  rv_isa_pkg::word_t      bus_rdata_i,
    input  logic                   bus_full_i
);

    core_bus_pkg::seq_state_t state;
    rv_isa_pkg::word_t        pc;
    rv_isa_pkg::word_t        ir;
    rv_isa_pkg::word_t        next_pc;
    logic                     is_mem_op;

    always_comb begin
        is_mem_op = dec_i.is_load | dec_i.is_store;
        // jal and taken branches jump relative to this instruction
        if (dec_i.is_jal || (dec_i.is_branch && branch_taken_i)) begin
            next_pc = pc + dec_i.imm;
        end else begin
            next_pc = pc + core_bus_pkg::PC_STEP;
        end
    end

    // bus request comes straight from state, pc and the current instruction.
    // none of these move while a transfer is stalled
    always_comb begin
        bus_req_o = '0;
        case (state)
            core_bus_pkg::S_FETCH: begin
                bus_req_o.rd   = 1'b1;
                bus_req_o.addr = pc;
            end
            core_bus_pkg::S_MEM: begin
                bus_req_o.rd    = dec_i.is_load;
                bus_req_o.wr    = dec_i.is_store;
                bus_req_o.addr  = mem_addr_i;
                bus_req_o.wdata = store_data_i;
            end
            default: bus_req_o = '0;
        endcase
    end

    // register write port takes alu results in exec and load data in mem
    always_comb begin
        rf_rd_o = dec_i.rd;
        if (state == core_bus_pkg::S_MEM) begin
            rf_we_o    = dec_i.is_load && !bus_full_i;
            rf_wdata_o = bus_rdata_i;
        end else begin
            rf_we_o    = (state == core_bus_pkg::S_EXEC) && dec_i.reg_we && !dec_i.is_load;
            rf_wdata_o = alu_result_i;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= core_bus_pkg::S_FETCH;
            pc    <= core_bus_pkg::RESET_PC;
            ir    <= rv_isa_pkg::INSTR_NOP;
        end else begin
            case (state)
                core_bus_pkg::S_FETCH: begin
                    if (!bus_full_i) begin // fetch completes
                        ir    <= bus_rdata_i;
                        state <= core_bus_pkg::S_EXEC;
                    end
                end
                core_bus_pkg::S_EXEC: begin
                    if (is_mem_op) begin
                        state <= core_bus_pkg::S_MEM;
                    end else begin
                        pc    <= next_pc;
                        state <= core_bus_pkg::S_FETCH;
                    end
                end
                core_bus_pkg::S_MEM: begin
                    if (!bus_full_i) begin
                        pc    <= pc + core_bus_pkg::PC_STEP;
                        state <= core_bus_pkg::S_FETCH;
                    end
                end
                default: state <= core_bus_pkg::S_FETCH;
            endcase
        end
    end

    assign instr_o = ir;
    assign pc_o    = pc;

endmodule

//--- src/cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
    input  logic                   clk,
    input  logic                   rst,
    output core_bus_pkg::bus_req_t bus_req_o,
    input  rv_isa_pkg::word_t      bus_rdata_i,
    input  logic                   bus_full_i
);

    rv_isa_pkg::word_t     instr;
    rv_isa_pkg::word_t     pc;
    rv_isa_pkg::decoded_t  dec;
    rv_isa_pkg::word_t     rs1_data;
    rv_isa_pkg::word_t     rs2_data;
    rv_isa_pkg::word_t     alu_result;
    rv_isa_pkg::word_t     mem_addr;
    logic                  branch_taken;
    logic                  rf_we;
    rv_isa_pkg::reg_addr_t rf_rd;
    rv_isa_pkg::word_t     rf_wdata;

    core_sequencer core_sequencer_i (
        .clk            (clk),
        .rst            (rst),
        .dec_i          (dec),
        .alu_result_i   (alu_result),
        .mem_addr_i     (mem_addr),
        .store_data_i   (rs2_data),     // store data is rs2
        .branch_taken_i (branch_taken),
        .instr_o        (instr),
        .pc_o           (pc),
        .rf_we_o        (rf_we),
        .rf_rd_o        (rf_rd),
        .rf_wdata_o     (rf_wdata),
        .bus_req_o      (bus_req_o),
        .bus_rdata_i    (bus_rdata_i),
        .bus_full_i     (bus_full_i)
    );

    instr_decoder instr_decoder_i (
        .instr_i (instr),
        .dec_o   (dec)
    );

    register_file register_file_i (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_i       (rf_rd),
        .wdata_i    (rf_wdata)
    );

    alu alu_i (
        .dec_i          (dec),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .pc_i           (pc),
        .alu_result_o   (alu_result),
        .mem_addr_o     (mem_addr),
        .branch_taken_o (branch_taken)
    );

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  rv_isa_pkg::word_t    instr_i,
    output rv_isa_pkg::decoded_t dec_o
);

    rv_isa_pkg::word_t imm_i_type;
    rv_isa_pkg::word_t imm_s_type;
    rv_isa_pkg::word_t imm_b_type;
    rv_isa_pkg::word_t imm_j_type;
    rv_isa_pkg::word_t imm_u_type;

    // every immediate format takes its sign from instr[31]
    always_comb begin
        imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
        imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};
        imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                      instr_i[20], instr_i[30:21], 1'b0};
        imm_u_type = {instr_i[31:12], 12'b0};
    end

    always_comb begin
        dec_o        = '0;
        dec_o.opcode = instr_i[6:0];
        dec_o.funct3 = instr_i[14:12];
        dec_o.funct7 = instr_i[31:25];
        dec_o.rs1    = instr_i[19:15];
        dec_o.rs2    = instr_i[24:20];
        dec_o.rd     = instr_i[11:7];
        case (instr_i[6:0])
            rv_isa_pkg::OP_REG: begin
                dec_o.reg_we = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                dec_o.imm     = imm_i_type;
                dec_o.use_imm = 1'b1;
                dec_o.reg_we  = 1'b1;
            end
            rv_isa_pkg::OP_LOAD: begin
                dec_o.imm     = imm_i_type;
                dec_o.use_imm = 1'b1;
                dec_o.reg_we  = 1'b1; // written in S_MEM
                dec_o.is_load = 1'b1;
            end
            rv_isa_pkg::OP_STORE: begin
                dec_o.imm      = imm_s_type;
                dec_o.use_imm  = 1'b1;
                dec_o.is_store = 1'b1;
            end
            rv_isa_pkg::OP_BRANCH: begin
                dec_o.imm       = imm_b_type; // pc offset when taken
                dec_o.is_branch = 1'b1;
            end
            rv_isa_pkg::OP_JAL: begin
                dec_o.imm    = imm_j_type;
                dec_o.reg_we = 1'b1;
                dec_o.is_jal = 1'b1;
            end
            rv_isa_pkg::OP_LUI: begin
                dec_o.imm     = imm_u_type;
                dec_o.use_imm = 1'b1;
                dec_o.reg_we  = 1'b1;
            end
            default: begin
                dec_o = '0; // unknown opcode runs as a nop
            end
        endcase
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_isa_pkg::reg_addr_t rs1_i,
    input  rv_isa_pkg::reg_addr_t rs2_i,
    output rv_isa_pkg::word_t     rs1_data_o,
    output rv_isa_pkg::word_t     rs2_data_o,
    input  logic                  we_i,
    input  rv_isa_pkg::reg_addr_t rd_i,
    input  rv_isa_pkg::word_t     wdata_i
);

    rv_isa_pkg::word_t regs [rv_isa_pkg::NUM_REGS];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin // x0 stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    // combinational read ports
    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // field widths
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [6:0]        opcode_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [6:0]        funct7_t;

    // major opcodes of the kept subset
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_LUI    = 7'b0110111;

    // alu funct3
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLL = 3'b001;
    localparam funct3_t F3_SLT = 3'b010; // executes as add
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_SRL = 3'b101;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // branch funct3
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    localparam funct7_t F7_SUB = 7'b0100000;

    // addi x0, x0, 0
    localparam word_t INSTR_NOP = 32'h0000_0013;

    typedef struct packed {
        opcode_t   opcode;
        funct3_t   funct3;
        funct7_t   funct7;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;       // already sign-extended
        logic      use_imm;   // second alu operand is imm
        logic      reg_we;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      is_jal;
    } decoded_t;

endpackage
